/* dcache_pkg.sv */
// Widths are fixed at 32-bit byte addresses and 4-word lines; CACHE_DEPTH stays a module parameter

package dcache_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------

    // Byte address width of both Wishbone sides
    localparam int ADDR_WIDTH = 32;
    // Data word width of both Wishbone sides
    localparam int WORD_WIDTH = 32;
    // One select bit per byte lane
    localparam int SEL_WIDTH = WORD_WIDTH / 8;

    // ----------------------------------------
    // Line geometry
    // ----------------------------------------

    // Words held by one cache line
    localparam int LINE_WORDS = 4;
    // Bits that pick a word inside a line
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS);
    // Address bits below the word, always zero on the memory side
    localparam int BYTE_OFFSET = $clog2(SEL_WIDTH);

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [SEL_WIDTH-1:0]    sel_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

endpackage

/* dcache_status_memory.sv */
// CACHE_DEPTH must be a power of two; only valid bits are reset, dirty bits of invalid lines are junk
`timescale 1ns/1ps

module dcache_status_memory #(
    parameter int CACHE_DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(CACHE_DEPTH)
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Port 0 is read/write and serves the line being filled or written
    input  logic [INDEX_WIDTH-1:0] port0_index_i,
    input  logic                   port0_valid_i,
    input  logic                   port0_dirty_i,
    input  logic                   port0_valid_write_i,
    input  logic                   port0_dirty_write_i,
    input  logic                   port0_read_i,
    output logic                   port0_dirty_o,
    // Port 1 is read-only and serves the lookup
    input  logic [INDEX_WIDTH-1:0] port1_index_i,
    input  logic                   port1_read_i,
    output logic                   port1_valid_o,
    output logic                   port1_dirty_o
);

    // ----------------------------------------
    // Valid bank
    // ----------------------------------------

    // Kept as a flat vector so that reset can clear every line at once
    logic [CACHE_DEPTH-1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (port0_valid_write_i) begin
            valid_q[port0_index_i] <= port0_valid_i;
        end
    end

    // A read in the same cycle as a port 0 write still sees the old bit
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_valid_o <= valid_q[port1_index_i];
        end
    end

    // ----------------------------------------
    // Dirty bank
    // ----------------------------------------

    logic dirty_q [CACHE_DEPTH];

    always_ff @(posedge clk_i) begin
        if (port0_dirty_write_i) begin
            dirty_q[port0_index_i] <= port0_dirty_i;
        end
    end

    // Port 0 readback lets the controller re-check a line before evicting it
    always_ff @(posedge clk_i) begin
        if (port0_read_i) begin
            port0_dirty_o <= dirty_q[port0_index_i];
        end
        if (port1_read_i) begin
            port1_dirty_o <= dirty_q[port1_index_i];
        end
    end

endmodule

/* dcache_tag_memory.sv */
// CACHE_DEPTH must be a power of two; the tag array has no reset, the valid bit qualifies it
`timescale 1ns/1ps

module dcache_tag_memory #(
    parameter int CACHE_DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(CACHE_DEPTH),
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH
                               - dcache_pkg::OFFSET_WIDTH - dcache_pkg::BYTE_OFFSET
) (
    input  logic                   clk_i,
    // Lookup port
    input  logic [INDEX_WIDTH-1:0] read_index_i,
    input  logic                   read_i,
    output logic [TAG_WIDTH-1:0]   tag_o,
    // Update port, written once a refill completes
    input  logic [INDEX_WIDTH-1:0] write_index_i,
    input  logic                   write_i,
    input  logic [TAG_WIDTH-1:0]   write_tag_i
);

    // One tag per line
    logic [TAG_WIDTH-1:0] tag_q [CACHE_DEPTH];

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            tag_q[write_index_i] <= write_tag_i;
        end
    end

    // The output holds between reads, so the evicted tag stays put during a write-back
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            tag_o <= tag_q[read_index_i];
        end
    end

endmodule

/* dcache_data_memory.sv */
// CACHE_DEPTH must be a power of two; one read and one write per cycle, a colliding read gets old data
`timescale 1ns/1ps

module dcache_data_memory #(
    parameter int CACHE_DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(CACHE_DEPTH)
) (
    input  logic                        clk_i,
    // Registered read port
    input  logic [INDEX_WIDTH-1:0]      read_index_i,
    input  dcache_pkg::offset_t         read_offset_i,
    input  logic                        read_i,
    output dcache_pkg::word_t           read_data_o,
    // Byte-masked write port, no lanes selected means no write
    input  logic [INDEX_WIDTH-1:0]      write_index_i,
    input  dcache_pkg::offset_t         write_offset_i,
    input  dcache_pkg::sel_t            write_sel_i,
    input  dcache_pkg::word_t           write_data_i
);

    // ----------------------------------------
    // Word array, index above offset
    // ----------------------------------------

    dcache_pkg::word_t word_q [CACHE_DEPTH * dcache_pkg::LINE_WORDS];

    always_ff @(posedge clk_i) begin
        // Refills select all four lanes, processor writes only their own
        for (int b = 0; b < dcache_pkg::SEL_WIDTH; b++) begin
            if (write_sel_i[b]) begin
                word_q[{write_index_i, write_offset_i}][8*b +: 8] <= write_data_i[8*b +: 8];
            end
        end
    end

    // The read register holds its value until the next enabled read
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            read_data_o <= word_q[{read_index_i, read_offset_i}];
        end
    end

endmodule

/* dcache_controller.sv */
// Single outstanding request; the processor holds its request until ack, aborts still finish the line
`timescale 1ns/1ps

module dcache_controller #(
    parameter int CACHE_DEPTH = 16,
    localparam int INDEX_WIDTH = $clog2(CACHE_DEPTH),
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH
                               - dcache_pkg::OFFSET_WIDTH - dcache_pkg::BYTE_OFFSET
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Processor side, Wishbone classic slave
    input  logic                   cpu_cyc_i,
    input  logic                   cpu_stb_i,
    input  logic                   cpu_we_i,
    input  dcache_pkg::addr_t      cpu_adr_i,
    input  dcache_pkg::word_t      cpu_dat_i,
    input  dcache_pkg::sel_t       cpu_sel_i,
    output logic                   cpu_ack_o,
    // Memory side, Wishbone classic master
    output logic                   mem_cyc_o,
    output logic                   mem_stb_o,
    output logic                   mem_we_o,
    output dcache_pkg::addr_t      mem_adr_o,
    output dcache_pkg::word_t      mem_dat_o,
    output dcache_pkg::sel_t       mem_sel_o,
    input  dcache_pkg::word_t      mem_dat_i,
    input  logic                   mem_ack_i,
    // Lookup reads of all three memories
    output logic [INDEX_WIDTH-1:0] lookup_index_o,
    output logic                   lookup_read_o,
    input  logic [TAG_WIDTH-1:0]   tag_i,
    input  logic                   valid_i,
    input  logic                   dirty_i,
    // Writes to the requested line
    output logic [INDEX_WIDTH-1:0] line_index_o,
    output logic                   tag_write_o,
    output logic [TAG_WIDTH-1:0]   tag_write_data_o,
    output logic                   status_valid_o,
    output logic                   status_dirty_o,
    output logic                   status_valid_write_o,
    output logic                   status_dirty_write_o,
    output logic                   status_read_o,
    input  logic                   status_dirty_i,
    // Data memory ports
    output dcache_pkg::offset_t    data_read_offset_o,
    output logic                   data_read_o,
    input  dcache_pkg::word_t      data_i,
    output dcache_pkg::offset_t    data_write_offset_o,
    output dcache_pkg::sel_t       data_write_sel_o,
    output dcache_pkg::word_t      data_write_data_o
);

    localparam int INDEX_LSB = dcache_pkg::BYTE_OFFSET + dcache_pkg::OFFSET_WIDTH;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_refill,
        st_update
    } state_t;

    state_t              state_q, state_d;
    dcache_pkg::offset_t beat_q, beat_d;
    dcache_pkg::addr_t   req_adr_q;
    logic                req_we_q;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [INDEX_WIDTH-1:0] req_index;
    dcache_pkg::offset_t    req_offset;
    logic                cpu_active;
    logic                hit;
    logic                last_beat;

    // ----------------------------------------
    // Request split and hit check
    // ----------------------------------------

    assign req_tag    = req_adr_q[dcache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index  = req_adr_q[INDEX_LSB +: INDEX_WIDTH];
    assign req_offset = req_adr_q[dcache_pkg::BYTE_OFFSET +: dcache_pkg::OFFSET_WIDTH];
    assign cpu_active = cpu_cyc_i && cpu_stb_i;
    assign hit        = valid_i && (tag_i == req_tag);
    assign last_beat  = (beat_q == dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1));

    // All writes target the requested line, and a refill always installs its tag
    assign line_index_o     = req_index;
    assign tag_write_data_o = req_tag;
    // Write-back beats take data straight from the registered data read
    assign mem_dat_o = data_i;
    assign mem_stb_o = mem_cyc_o;
    assign mem_sel_o = '1;

    // Request is captured when the lookup starts so an abort cannot corrupt a miss
    always_ff @(posedge clk_i) begin
        if (state_q == st_idle && cpu_active) begin
            req_adr_q <= cpu_adr_i;
            req_we_q  <= cpu_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_idle;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            beat_q  <= beat_d;
        end
    end

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------

    always_comb begin
        state_d              = state_q;
        beat_d               = beat_q;
        lookup_index_o       = req_index;
        lookup_read_o        = 1'b0;
        data_read_offset_o   = req_offset;
        data_read_o          = 1'b0;
        data_write_offset_o  = req_offset;
        data_write_sel_o     = '0;
        data_write_data_o    = cpu_dat_i;
        tag_write_o          = 1'b0;
        status_valid_o       = 1'b0;
        status_dirty_o       = 1'b0;
        status_valid_write_o = 1'b0;
        status_dirty_write_o = 1'b0;
        status_read_o        = 1'b0;
        cpu_ack_o            = 1'b0;
        mem_cyc_o            = 1'b0;
        mem_we_o             = 1'b0;
        mem_adr_o = {req_tag, req_index, beat_q, {dcache_pkg::BYTE_OFFSET{1'b0}}};

        case (state_q)
            st_idle: begin
                // Lookup index comes straight from the bus to save a cycle
                lookup_index_o     = cpu_adr_i[INDEX_LSB +: INDEX_WIDTH];
                data_read_offset_o = cpu_adr_i[dcache_pkg::BYTE_OFFSET +: dcache_pkg::OFFSET_WIDTH];
                if (cpu_active) begin
                    lookup_read_o = 1'b1;
                    data_read_o   = 1'b1;
                    state_d       = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    state_d = st_idle;
                    // An aborted request is dropped here without ack or write
                    if (cpu_active) begin
                        cpu_ack_o = 1'b1;
                        if (req_we_q) begin
                            data_write_sel_o     = cpu_sel_i;
                            status_dirty_o       = 1'b1;
                            status_dirty_write_o = 1'b1;
                        end
                    end
                end else begin
                    // Prefetch word 0 for a possible write-back and re-read the dirty bit
                    data_read_offset_o = '0;
                    data_read_o        = 1'b1;
                    status_read_o      = 1'b1;
                    state_d = (valid_i && dirty_i) ? st_writeback : st_refill;
                end
            end
            st_writeback: begin
                if (!status_dirty_i) begin
                    state_d = st_refill;
                end else begin
                    mem_cyc_o = 1'b1;
                    mem_we_o  = 1'b1;
                    mem_adr_o = {tag_i, req_index, beat_q, {dcache_pkg::BYTE_OFFSET{1'b0}}};
                    if (mem_ack_i) begin
                        // Fetch the next word while the counter moves on
                        data_read_offset_o = beat_q + dcache_pkg::offset_t'(1);
                        data_read_o        = 1'b1;
                        beat_d             = beat_q + dcache_pkg::offset_t'(1);
                        if (last_beat) begin
                            state_d = st_refill;
                        end
                    end
                end
            end
            st_refill: begin
                mem_cyc_o = 1'b1;
                if (mem_ack_i) begin
                    data_write_offset_o = beat_q;
                    data_write_sel_o    = '1;
                    data_write_data_o   = mem_dat_i;
                    beat_d              = beat_q + dcache_pkg::offset_t'(1);
                    // Last beat installs the tag and marks the line valid and clean
                    if (last_beat) begin
                        tag_write_o          = 1'b1;
                        status_valid_o       = 1'b1;
                        status_valid_write_o = 1'b1;
                        status_dirty_write_o = 1'b1;
                        state_d              = st_update;
                    end
                end
            end
            st_update: begin
                // Re-lookup now sees the new line, so compare will hit
                lookup_read_o = 1'b1;
                data_read_o   = 1'b1;
                state_d       = st_compare;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

/* dcache_top.sv */
// CACHE_DEPTH must be a power of two of 2 or more; no flush, no uncached space, no bus errors
`timescale 1ns/1ps

module dcache_top #(
    parameter int CACHE_DEPTH = 16
) (
    input  logic              clk_i,
    input  logic              rst_i,
    // Processor side
    input  logic              cpu_cyc_i,
    input  logic              cpu_stb_i,
    input  logic              cpu_we_i,
    input  dcache_pkg::addr_t cpu_adr_i,
    input  dcache_pkg::word_t cpu_dat_i,
    input  dcache_pkg::sel_t  cpu_sel_i,
    output dcache_pkg::word_t cpu_dat_o,
    output logic              cpu_ack_o,
    // Memory side
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_adr_o,
    output dcache_pkg::word_t mem_dat_o,
    output dcache_pkg::sel_t  mem_sel_o,
    input  dcache_pkg::word_t mem_dat_i,
    input  logic              mem_ack_i
);

    localparam int INDEX_WIDTH = $clog2(CACHE_DEPTH);
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH
                               - dcache_pkg::OFFSET_WIDTH - dcache_pkg::BYTE_OFFSET;

    // ----------------------------------------
    // Controller to memory wiring
    // ----------------------------------------

    logic [INDEX_WIDTH-1:0] lookup_index;
    logic                   lookup_read;
    logic [INDEX_WIDTH-1:0] line_index;
    logic [TAG_WIDTH-1:0]   tag;
    logic [TAG_WIDTH-1:0]   tag_write_data;
    logic                   tag_write;
    logic                   valid;
    logic                   dirty;
    logic                   status_valid;
    logic                   status_dirty;
    logic                   status_valid_write;
    logic                   status_dirty_write;
    logic                   status_read;
    logic                   status_dirty_rb;
    dcache_pkg::offset_t    data_read_offset;
    logic                   data_read;
    dcache_pkg::word_t      data_read_data;
    dcache_pkg::offset_t    data_write_offset;
    dcache_pkg::sel_t       data_write_sel;
    dcache_pkg::word_t      data_write_data;

    // Read hits return the registered data word directly
    assign cpu_dat_o = data_read_data;

    dcache_controller #(.CACHE_DEPTH(CACHE_DEPTH)) controller_i (
        .clk_i, .rst_i,
        .cpu_cyc_i, .cpu_stb_i, .cpu_we_i, .cpu_adr_i, .cpu_dat_i, .cpu_sel_i, .cpu_ack_o,
        .mem_cyc_o, .mem_stb_o, .mem_we_o, .mem_adr_o, .mem_dat_o, .mem_sel_o,
        .mem_dat_i, .mem_ack_i,
        .lookup_index_o       (lookup_index),
        .lookup_read_o        (lookup_read),
        .tag_i                (tag),
        .valid_i              (valid),
        .dirty_i              (dirty),
        .line_index_o         (line_index),
        .tag_write_o          (tag_write),
        .tag_write_data_o     (tag_write_data),
        .status_valid_o       (status_valid),
        .status_dirty_o       (status_dirty),
        .status_valid_write_o (status_valid_write),
        .status_dirty_write_o (status_dirty_write),
        .status_read_o        (status_read),
        .status_dirty_i       (status_dirty_rb),
        .data_read_offset_o   (data_read_offset),
        .data_read_o          (data_read),
        .data_i               (data_read_data),
        .data_write_offset_o  (data_write_offset),
        .data_write_sel_o     (data_write_sel),
        .data_write_data_o    (data_write_data)
    );

    dcache_status_memory #(.CACHE_DEPTH(CACHE_DEPTH)) status_memory_i (
        .clk_i, .rst_i,
        .port0_index_i       (line_index),
        .port0_valid_i       (status_valid),
        .port0_dirty_i       (status_dirty),
        .port0_valid_write_i (status_valid_write),
        .port0_dirty_write_i (status_dirty_write),
        .port0_read_i        (status_read),
        .port0_dirty_o       (status_dirty_rb),
        .port1_index_i       (lookup_index),
        .port1_read_i        (lookup_read),
        .port1_valid_o       (valid),
        .port1_dirty_o       (dirty)
    );

    dcache_tag_memory #(.CACHE_DEPTH(CACHE_DEPTH)) tag_memory_i (
        .clk_i,
        .read_index_i  (lookup_index),
        .read_i        (lookup_read),
        .tag_o         (tag),
        .write_index_i (line_index),
        .write_i       (tag_write),
        .write_tag_i   (tag_write_data)
    );

    dcache_data_memory #(.CACHE_DEPTH(CACHE_DEPTH)) data_memory_i (
        .clk_i,
        .read_index_i   (lookup_index),
        .read_offset_i  (data_read_offset),
        .read_i         (data_read),
        .read_data_o    (data_read_data),
        .write_index_i  (line_index),
        .write_offset_i (data_write_offset),
        .write_sel_i    (data_write_sel),
        .write_data_i   (data_write_data)
    );

endmodule

/* tb_dcache_mem_model.sv */
// Wishbone classic slave memory; one access per ack, delay of 1 to 4 cycles, addresses wrap at DEPTH_WORDS
`timescale 1ns/1ps

module tb_dcache_mem_model #(
    parameter int DEPTH_WORDS = 1024,
    parameter logic [31:0] FILL_PATTERN = 32'h5A00_0000
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  dcache_pkg::addr_t adr_i,
    input  dcache_pkg::word_t dat_i,
    input  dcache_pkg::sel_t  sel_i,
    output dcache_pkg::word_t dat_o,
    output logic              ack_o
);

    localparam int WORD_BITS = $clog2(DEPTH_WORDS);

    // Memory contents, read back by the testbench after write-backs
    dcache_pkg::word_t mem_q [DEPTH_WORDS];

    logic [WORD_BITS-1:0] word_adr;
    int                   wait_cnt;
    int                   ack_seed;
    int                   rnd;

    assign word_adr = adr_i[WORD_BITS+1:2];

    // Every word starts as its own word address plus the fill pattern
    initial begin
        ack_seed = 32'h3462_70e7;
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem_q[i] = FILL_PATTERN + 32'(i);
        end
    end

    // ----------------------------------------
    // Beat handling
    // ----------------------------------------

    always @(posedge clk_i) begin
        if (rst_i) begin
            ack_o    <= 1'b0;
            dat_o    <= '0;
            wait_cnt <= 0;
        end else if (ack_o) begin
            // The ack lasts one cycle, then a fresh random delay is drawn
            ack_o    <= 1'b0;
            rnd      = $random(ack_seed);
            wait_cnt <= rnd & 3;
        end else if (cyc_i && stb_i) begin
            if (wait_cnt == 0) begin
                ack_o <= 1'b1;
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem_q[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end else begin
                    dat_o <= mem_q[word_adr];
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

/* tb_dcache.sv */
// Testbench for dcache_top with 16 lines; random accesses stay inside an 8 KB window at address 0
`timescale 1ns/1ps

module tb_dcache;

    localparam int          TIMEOUT   = 200;
    localparam int          REF_WORDS = 2048;
    localparam logic [31:0] FILL      = 32'h5A00_0000;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic cpu_cyc_i = 1'b0, cpu_stb_i = 1'b0, cpu_we_i = 1'b0;
    dcache_pkg::addr_t cpu_adr_i = '0;
    dcache_pkg::word_t cpu_dat_i = '0;
    dcache_pkg::sel_t  cpu_sel_i = '0;
    dcache_pkg::word_t cpu_dat_o, mem_dat_o, mem_dat_i;
    dcache_pkg::addr_t mem_adr_o;
    dcache_pkg::sel_t  mem_sel_o;
    logic cpu_ack_o, mem_cyc_o, mem_stb_o, mem_we_o, mem_ack_i;

    dcache_pkg::word_t ref_q [REF_WORDS];
    int                resident_q [16];
    dcache_pkg::addr_t beat_adr_q [$];
    logic              beat_we_q [$];
    int   error_count = 0, pass_count = 0, fail_count = 0, seed = 32'h3462_70e7;
    logic no_mem_expected = 1'b0, rst_seen = 1'b0, ack_prev = 1'b0, wait_prev = 1'b0, we_prev;
    dcache_pkg::addr_t adr_prev;
    event timeout_ev;

    dcache_top #(.CACHE_DEPTH(16)) dut_i (.*);

    tb_dcache_mem_model #(.DEPTH_WORDS(REF_WORDS), .FILL_PATTERN(FILL)) mem_model_i (
        .clk_i, .rst_i, .cyc_i(mem_cyc_o), .stb_i(mem_stb_o), .we_i(mem_we_o),
        .adr_i(mem_adr_o), .dat_i(mem_dat_o), .sel_i(mem_sel_o),
        .dat_o(mem_dat_i), .ack_o(mem_ack_i)
    );

    always #20 clk_i = ~clk_i;

    // ----------------------------------------
    // Bus monitor, sampled mid-cycle
    // ----------------------------------------

    always @(negedge clk_i) begin
        if (rst_i && rst_seen) begin
            assert (!cpu_ack_o && !mem_cyc_o && !mem_stb_o) else begin
                $display("Bus outputs active during reset at %0t", $time);
                error_count++;
            end
        end
        assert (!(ack_prev && cpu_ack_o)) else begin
            $display("cpu_ack_o high for two cycles in a row at %0t", $time);
            error_count++;
        end
        // A beat that saw no ack last cycle must hold its address and direction
        if (wait_prev && mem_cyc_o) begin
            assert (mem_adr_o == adr_prev && mem_we_o == we_prev) else begin
                $display("Mismatch at %0t: memory beat changed while waiting", $time);
                error_count++;
            end
        end
        // Every memory beat carries all four byte lanes
        if (mem_cyc_o) begin
            assert (mem_sel_o == 4'hF) else begin
                $display("Mismatch at %0t: mem_sel_o %h is not all ones", $time, mem_sel_o);
                error_count++;
            end
        end
        if (no_mem_expected) begin
            assert (!mem_cyc_o) else begin
                $display("Memory cycle started during a hit at %0t", $time);
                error_count++;
            end
        end
        if (mem_cyc_o && mem_stb_o && mem_ack_i) begin
            beat_adr_q.push_back(mem_adr_o);
            beat_we_q.push_back(mem_we_o);
        end
        rst_seen  = rst_i;
        ack_prev  = cpu_ack_o;
        wait_prev = mem_cyc_o && !mem_ack_i;
        adr_prev  = mem_adr_o;
        we_prev   = mem_we_o;
    end

    initial begin
        @(timeout_ev);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------
    // Checks and processor access
    // ----------------------------------------

    function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old_w,
                                                       dcache_pkg::word_t new_w,
                                                       dcache_pkg::sel_t sel);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_word(input string what, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Checks the beat log against one optional write-back line and one refill line
    task automatic check_beats(input int wb_line, input int fill_line);
        int n;
        int k;
        n = (wb_line >= 0) ? 8 : 4;
        check_word("beat count", beat_adr_q.size(), n);
        for (k = 0; k < n && k < beat_adr_q.size(); k++) begin
            check_word("beat direction", beat_we_q[k], (k < n - 4) ? 1 : 0);
            check_word("beat address", beat_adr_q[k],
                       (((k < n - 4) ? wb_line : fill_line) << 4) + 4 * (k % 4));
        end
        beat_adr_q.delete();
        beat_we_q.delete();
    endtask

    task automatic cpu_access(input logic we, input dcache_pkg::addr_t adr,
                              input dcache_pkg::word_t dat, input dcache_pkg::sel_t sel,
                              output dcache_pkg::word_t rdata, output int cycles);
        logic ack_seen;
        ack_seen  = 1'b0;
        cycles    = 0;
        cpu_cyc_i = 1'b1;
        cpu_stb_i = 1'b1;
        cpu_we_i  = we;
        cpu_adr_i = adr;
        cpu_dat_i = dat;
        cpu_sel_i = sel;
        while (!ack_seen) begin
            @(negedge clk_i);
            cycles++;
            if (cpu_ack_o) begin
                ack_seen = 1'b1;
                rdata    = cpu_dat_o;
            end else if (cycles >= TIMEOUT) begin
                $display("Timeout: no cpu_ack_o within %0d cycles for address %h", TIMEOUT, adr);
                -> timeout_ev;
                forever @(posedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
        if (we) ref_q[adr[12:2]] = merge_bytes(ref_q[adr[12:2]], dat, sel);
        resident_q[adr[7:4]] = int'(adr[31:4]);
    endtask

    task automatic read_check(input dcache_pkg::addr_t adr, output int cycles);
        dcache_pkg::word_t rdata;
        cpu_access(1'b0, adr, '0, '0, rdata, cycles);
        check_word("read data", rdata, ref_q[adr[12:2]]);
    endtask

    task automatic apply_reset();
        rst_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // Reset drops every line, so nothing is resident any more
        for (int i = 0; i < 16; i++) resident_q[i] = -1;
        beat_adr_q.delete();
        beat_we_q.delete();
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("Test %s: PASS", name);
        end else begin
            fail_count++;
            $display("Test %s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        dcache_pkg::word_t rdata;
        dcache_pkg::addr_t adr;
        int cycles, e0, rnd_adr, rnd_dat, rnd_ctl;
        // Memory starts with each word at its word address plus the fill pattern
        for (int i = 0; i < REF_WORDS; i++) ref_q[i] = FILL + 32'(i);
        apply_reset();

        e0 = error_count;
        read_check(32'h40, cycles);
        check_beats(-1, 4);
        end_test("read miss", e0);

        e0 = error_count;
        no_mem_expected = 1'b1;
        read_check(32'h48, cycles);
        no_mem_expected = 1'b0;
        check_word("hit latency", cycles, 2);
        end_test("read hit", e0);

        e0 = error_count;
        cpu_access(1'b1, 32'h44, 32'hDEAD_BEEF, 4'b0101, rdata, cycles);
        read_check(32'h44, cycles);
        check_word("beats after write hit", beat_adr_q.size(), 0);
        end_test("byte write hit", e0);

        e0 = error_count;
        read_check(32'h000, cycles);
        cpu_access(1'b1, 32'h004, 32'h1234_5678, 4'b1111, rdata, cycles);
        cpu_access(1'b1, 32'h008, 32'hCAFE_F00D, 4'b1100, rdata, cycles);
        beat_adr_q.delete();
        beat_we_q.delete();
        read_check(32'h100, cycles);
        check_beats(0, 16);
        for (int i = 0; i < 4; i++) check_word("evicted word", mem_model_i.mem_q[i], ref_q[i]);
        read_check(32'h204, cycles);
        check_beats(-1, 32);
        end_test("dirty eviction", e0);

        e0 = error_count;
        for (int n = 0; n < 300; n++) begin
            rnd_adr = $random(seed);
            rnd_dat = $random(seed);
            rnd_ctl = $random(seed);
            adr = dcache_pkg::addr_t'(rnd_adr & 32'h0000_1FFC);
            if (rnd_ctl[4]) begin
                cpu_access(1'b1, adr, rnd_dat, rnd_ctl[3:0], rdata, cycles);
            end else begin
                read_check(adr, cycles);
            end
        end
        // Lines no longer in the cache must have reached memory
        for (int w = 0; w < REF_WORDS; w++) begin
            if (resident_q[(w >> 2) & 15] != (w >> 2)) begin
                check_word("flushed word", mem_model_i.mem_q[w], ref_q[w]);
            end
        end
        end_test("random sequence", e0);

        e0 = error_count;
        // An address above the random window always misses, so reset lands during a line fill
        cpu_cyc_i = 1'b1;
        cpu_stb_i = 1'b1;
        cpu_adr_i = 32'h0000_4000;
        cycles    = 0;
        while (!mem_cyc_o) begin
            @(negedge clk_i);
            cycles++;
            if (!mem_cyc_o && cycles >= TIMEOUT) begin
                $display("Timeout: no memory cycle within %0d cycles before reset", TIMEOUT);
                -> timeout_ev;
                forever @(posedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        apply_reset();
        // Dirty lines are lost with reset, so memory now holds the only copy
        for (int i = 0; i < REF_WORDS; i++) ref_q[i] = mem_model_i.mem_q[i];
        read_check(32'h40, cycles);
        check_beats(-1, 4);
        read_check(32'h100, cycles);
        check_beats(-1, 16);
        end_test("reset", e0);

        $display("Tests passed: %0d failed: %0d errors: %0d", pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
dcache_pkg.sv
dcache_status_memory.sv
dcache_tag_memory.sv
dcache_data_memory.sv
dcache_controller.sv
dcache_top.sv
tb_dcache_mem_model.sv
tb_dcache.sv

/* Makefile */
# Verilator flow for the data cache testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log is searched for the pass line, so a crash or a failure both end non-zero
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
